// File: sdmac_fifo.f
common/fifo_pkg.sv
common/fifo_wr_if.sv
fifo/fifo_buffer.sv
hdl/fifo_arbiter.sv
hdl/cpu_word_loader.sv
hdl/scsi_byte_loader.sv
hdl/sdmac_fifo.sv
sim/tb_clock.sv
sim/sdmac_fifo_properties.sv
sim/sdmac_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the sdmac_fifo testbench with Verilator
# Exits nonzero when the build fails or the simulation stops on an error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sdmac_fifo_tb -Mdir obj_dir -f sdmac_fifo.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vsdmac_fifo_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

// File: sim/sdmac_fifo_tb.sv
/* Table-driven testbench for the SCSI DMA data FIFO with DEPTH 8
   Each row waits 4 cycles, enough for a host write delayed by a SCSI conflict */
`timescale 1ns/100ps

module sdmac_fifo_tb;

  localparam int          DEPTH    = 8;
  localparam int          ROW_WAIT = 4;              // Cycles per row, keeps strobes 4 apart
  localparam logic [31:0] MASK_ALL = 32'hffff_ffff;
  localparam logic [31:0] MASK_LOW = 32'h0000_ffff;  // Entry started at byte 2

  typedef enum logic [2:0] {
    OP_CPU_HI,  // lhword
    OP_CPU_LO,  // llword, completes a host entry
    OP_SCSI,    // lbyte
    OP_ACR,     // ACR write, mid25 picks the start byte
    OP_POP,
    OP_FLUSH,   // rst_fifo
    OP_BOTH     // llword and lbyte on the same edge
  } op_t;

  typedef struct packed {
    op_t         op;
    logic [31:0] data;   // Driven on id
    logic        mid25;
    logic [31:0] mask;   // Bits of od checked after the row
  } row_t;

  logic        LLWS;
  logic        reset;
  logic        lhword;
  logic        llword;
  logic        lbyte;
  logic        acr_wr;
  logic        mid25;
  logic        pop;
  logic        rst_fifo;
  logic [31:0] id;
  logic [31:0] od;
  logic        fifo_full;
  logic        fifo_empty;
  logic        boeq0;
  logic        boeq3;
  logic [1:0]  bo;

  // Reference model
  logic [31:0] shadow [DEPTH];  // Image of the buffer storage
  logic [31:0] expq [$];        // Committed entries in pop order
  int          m_wr;            // Slot being filled
  logic [1:0]  m_bo;            // Byte pointer

  row_t rows [$];
  int   seed;
  int   cycles;
  int   cycle_limit;

  tb_clock u_clock (
    .LLWS  (LLWS),
    .reset (reset)
  );

  sdmac_fifo #(
    .DEPTH (DEPTH)
  ) DUT (
    .LLWS       (LLWS),
    .reset      (reset),
    .lhword     (lhword),
    .llword     (llword),
    .lbyte      (lbyte),
    .acr_wr     (acr_wr),
    .mid25      (mid25),
    .pop        (pop),
    .rst_fifo   (rst_fifo),
    .id         (id),
    .od         (od),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .boeq0      (boeq0),
    .boeq3      (boeq3),
    .bo         (bo)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Run guard
  always @(posedge LLWS) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) fail_run("Timeout, the run went past its cycle limit");
  end

  task automatic next_cycle();
    @(posedge LLWS);
    #10;  // Drive point after the edge
  endtask

  task automatic clear_strobes();
    lhword   = 1'b0;
    llword   = 1'b0;
    lbyte    = 1'b0;
    acr_wr   = 1'b0;
    pop      = 1'b0;
    rst_fifo = 1'b0;
  endtask

  task automatic add_row(input op_t op, input logic m25, input logic [31:0] mask);
    row_t r;
    r.op    = op;
    r.data  = $random(seed);
    r.mid25 = m25;
    r.mask  = mask;
    rows.push_back(r);
  endtask

  // Lane write into the slot under assembly, lost entirely when full
  task automatic write_lanes(input logic [3:0] lanes, input logic [31:0] word,
                             input logic commit);
    if (expq.size() == DEPTH) return;
    for (int b = 0; b < 4; b++) begin
      if (lanes[3-b]) shadow[m_wr][31-8*b -: 8] = word[31-8*b -: 8];  // Byte 0 on top
    end
    if (commit) begin
      expq.push_back(shadow[m_wr]);
      m_wr = (m_wr + 1) % DEPTH;
    end
  endtask

  task automatic load_byte(input logic [7:0] value);
    write_lanes(4'b1000 >> m_bo, {4{value}}, m_bo == 2'd3);  // Fourth byte commits
    m_bo = m_bo + 2'd1;
  endtask

  task automatic update_model(input row_t r);
    case (r.op)
      OP_CPU_HI: write_lanes(4'b1100, r.data, 1'b0);
      OP_CPU_LO: write_lanes(4'b0011, r.data, 1'b1);
      OP_SCSI:   load_byte(r.data[7:0]);
      OP_ACR:    m_bo = r.mid25 ? 2'd2 : 2'd0;
      OP_POP: begin
        if (expq.size() > 0) void'(expq.pop_front());  // Empty pop ignored
      end
      OP_FLUSH: begin
        expq.delete();
        m_wr = 0;
        m_bo = 2'd0;
      end
      default: begin
        load_byte(r.data[7:0]);  // SCSI takes the port first
        write_lanes(4'b0011, r.data, 1'b1);
      end
    endcase
  endtask

  task automatic drive_row(input row_t r);
    id       = r.data;
    mid25    = r.mid25;
    lhword   = (r.op == OP_CPU_HI);
    llword   = (r.op == OP_CPU_LO) || (r.op == OP_BOTH);
    lbyte    = (r.op == OP_SCSI) || (r.op == OP_BOTH);
    acr_wr   = (r.op == OP_ACR);
    pop      = (r.op == OP_POP);
    rst_fifo = (r.op == OP_FLUSH);
    next_cycle();
    clear_strobes();  // Single-cycle pulses
    repeat (ROW_WAIT - 1) next_cycle();
  endtask

  task automatic verify_outputs(input string tag, input logic [31:0] mask);
    check_value({tag, " fifo_empty"}, 32'(expq.size() == 0), 32'(fifo_empty));
    check_value({tag, " fifo_full"}, 32'(expq.size() == DEPTH), 32'(fifo_full));
    check_value({tag, " bo"}, 32'(m_bo), 32'(bo));
    check_value({tag, " boeq0"}, 32'(m_bo == 2'd0), 32'(boeq0));
    check_value({tag, " boeq3"}, 32'(m_bo == 2'd3), 32'(boeq3));
    if (expq.size() > 0) check_value({tag, " od"}, expq[0] & mask, od & mask);
  endtask

  task automatic build_table();
    // Host words pop in order
    repeat (2) begin
      add_row(OP_CPU_HI, 1'b0, MASK_ALL);
      add_row(OP_CPU_LO, 1'b0, MASK_ALL);
    end
    repeat (2) add_row(OP_POP, 1'b0, MASK_ALL);
    // Four bytes big-endian, pointer wraps
    repeat (4) add_row(OP_SCSI, 1'b0, MASK_ALL);
    add_row(OP_POP, 1'b0, MASK_ALL);
    // Aligned start at byte 2, upper half of this slot never written
    add_row(OP_ACR, 1'b1, MASK_ALL);
    repeat (2) add_row(OP_SCSI, 1'b0, MASK_LOW);
    add_row(OP_POP, 1'b0, MASK_ALL);
    add_row(OP_ACR, 1'b0, MASK_ALL);
    // Fill, the last word is dropped
    repeat (DEPTH + 1) begin
      add_row(OP_CPU_HI, 1'b0, MASK_ALL);
      add_row(OP_CPU_LO, 1'b0, MASK_ALL);
    end
    repeat (DEPTH) add_row(OP_POP, 1'b0, MASK_ALL);
    // Final SCSI byte and host low word on one edge
    add_row(OP_CPU_HI, 1'b0, MASK_ALL);
    repeat (3) add_row(OP_SCSI, 1'b0, MASK_ALL);
    add_row(OP_BOTH, 1'b0, MASK_ALL);
    repeat (2) add_row(OP_POP, 1'b0, MASK_ALL);
    // Flush with an entry stored and a byte pending
    add_row(OP_CPU_HI, 1'b0, MASK_ALL);
    add_row(OP_CPU_LO, 1'b0, MASK_ALL);
    add_row(OP_SCSI, 1'b0, MASK_ALL);
    add_row(OP_FLUSH, 1'b0, MASK_ALL);
    add_row(OP_CPU_HI, 1'b0, MASK_ALL);
    add_row(OP_CPU_LO, 1'b0, MASK_ALL);
    repeat (2) add_row(OP_POP, 1'b0, MASK_ALL);  // Second one while empty
  endtask

  initial begin
    seed      = 32'h5bd09690;
    cycles    = 0;
    m_wr      = 0;
    m_bo      = 2'd0;
    clear_strobes();
    id    = '0;
    mid25 = 1'b0;
    build_table();
    cycle_limit = rows.size() * 6 + 20;  // Covers reset too

    @(posedge LLWS);
    wait (reset === 1'b0);
    verify_outputs("reset", MASK_ALL);

    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      update_model(rows[i]);
      verify_outputs($sformatf("row %0d", i), rows[i].mask);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// File: sim/sdmac_fifo_properties.sv
/* Concurrent checks on arbiter grants, buffer flags and strobe spacing
   Bound into the FIFO top, where the strobes and both sides of the arbiter meet */
`timescale 1ns/100ps

module sdmac_fifo_properties (
  input logic LLWS,
  input logic reset,
  input logic rst_fifo,
  input logic pop,
  input logic lhword,
  input logic llword,
  input logic lbyte,
  input logic cpu_gnt,     // Arbiter grant to the host loader
  input logic scsi_gnt,    // Arbiter grant to the SCSI loader
  input logic buf_req,     // Write reaching the buffer
  input logic buf_commit,
  input logic fifo_full,
  input logic fifo_empty
);

  logic cpu_strobe;  // Either host half

  assign cpu_strobe = lhword | llword;

  // One write port, one winner
  a_one_grant: assert property (@(posedge LLWS) disable iff (reset)
    !(cpu_gnt && scsi_gnt))
    else $error("Both loaders granted in the same cycle");

  a_flags: assert property (@(posedge LLWS) disable iff (reset)
    !(fifo_full && fifo_empty))
    else $error("fifo_full and fifo_empty high together");

  // Completing write while full must leave the count at DEPTH
  a_full_drop: assert property (@(posedge LLWS) disable iff (reset)
    (fifo_full && buf_req && buf_commit && !pop && !rst_fifo) |=> fifo_full)
    else $error("Commit while full changed the occupancy");

  a_cpu_spacing: assert property (@(posedge LLWS) disable iff (reset)
    cpu_strobe |-> !$past(cpu_strobe) && !$past(cpu_strobe, 2))
    else $error("Host strobes closer than 3 cycles");

  a_scsi_spacing: assert property (@(posedge LLWS) disable iff (reset)
    lbyte |-> !$past(lbyte) && !$past(lbyte, 2))
    else $error("SCSI byte strobes closer than 3 cycles");

endmodule

bind sdmac_fifo sdmac_fifo_properties u_properties (
  .LLWS       (LLWS),
  .reset      (reset),
  .rst_fifo   (rst_fifo),
  .pop        (pop),
  .lhword     (lhword),
  .llword     (llword),
  .lbyte      (lbyte),
  .cpu_gnt    (cpu_wr.gnt),
  .scsi_gnt   (scsi_wr.gnt),
  .buf_req    (buf_wr.req),
  .buf_commit (buf_wr.commit),
  .fifo_full  (fifo_full),
  .fifo_empty (fifo_empty)
);

// File: sim/tb_clock.sv
/* Free-running 100 ns LLWS clock and a synchronous reset held for the first 8 rising edges
   Reset drops 10 ns after an edge, in step with the testbench stimulus */
`timescale 1ns/100ps

module tb_clock #(
  parameter int HALF_PERIOD  = 50,  // ns
  parameter int RESET_CYCLES = 8
) (
  output logic LLWS,
  output logic reset
);

  initial begin
    LLWS = 1'b0;
    forever #(HALF_PERIOD) LLWS = ~LLWS;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge LLWS);
    #10 reset = 1'b0;  // Same offset as the drive point
  end

endmodule

// File: hdl/sdmac_fifo.sv
/* SCSI DMA data FIFO top, host words and SCSI bytes share one buffer, all on LLWS
   Strobes are single-cycle pulses, stored data shows on od 2 cycles later, 3 on a conflict */
`timescale 1ns/100ps

module sdmac_fifo #(
  parameter int DEPTH = 8  // Entries in the buffer
) (
  input  logic        LLWS,
  input  logic        reset,
  input  logic        lhword,    // Host upper half strobe
  input  logic        llword,    // Host lower half strobe
  input  logic        lbyte,     // SCSI byte strobe
  input  logic        acr_wr,    // ACR write, presets the byte pointer
  input  logic        mid25,
  input  logic        pop,       // Consume head entry
  input  logic        rst_fifo,  // Flush
  input  logic [31:0] id,
  output logic [31:0] od,        // Head entry
  output logic        fifo_full,
  output logic        fifo_empty,
  output logic        boeq0,
  output logic        boeq3,
  output logic [1:0]  bo
);

  fifo_wr_if cpu_wr ();   // Host loader to arbiter
  fifo_wr_if scsi_wr ();  // SCSI loader to arbiter
  fifo_wr_if buf_wr ();   // Arbiter to buffer

  cpu_word_loader u_cpu_loader (
    .LLWS   (LLWS),
    .reset  (reset),
    .lhword (lhword),
    .llword (llword),
    .id     (id),
    .wr     (cpu_wr)
  );

  scsi_byte_loader u_scsi_loader (
    .LLWS     (LLWS),
    .reset    (reset),
    .rst_fifo (rst_fifo),
    .lbyte    (lbyte),
    .acr_wr   (acr_wr),
    .mid25    (mid25),
    .id       (id),
    .wr       (scsi_wr),
    .bo       (bo),
    .boeq0    (boeq0),
    .boeq3    (boeq3)
  );

  fifo_arbiter u_arbiter (
    .cpu      (cpu_wr),
    .scsi     (scsi_wr),
    .buf_port (buf_wr)
  );

  fifo_buffer #(
    .DEPTH (DEPTH)
  ) u_buffer (
    .LLWS       (LLWS),
    .reset      (reset),
    .rst_fifo   (rst_fifo),
    .pop        (pop),
    .wr         (buf_wr),
    .od         (od),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

endmodule

// File: hdl/scsi_byte_loader.sv
/* SCSI side loader, bytes fill an entry big-endian from the byte pointer, the fourth completes it
   An ACR write presets the pointer to 0 or to 2 for a 16-bit aligned start */
`timescale 1ns/100ps

module scsi_byte_loader (
  input  logic                LLWS,
  input  logic                reset,
  input  logic                rst_fifo,  // FIFO flush
  input  logic                lbyte,     // Byte strobe from the SCSI side
  input  logic                acr_wr,    // Address control register write
  input  logic                mid25,     // Transfer starts on a 16-bit boundary
  input  logic [31:0]         id,        // Byte in id[7:0]
  fifo_wr_if.loader           wr,
  output fifo_pkg::byte_ptr_t bo,        // Current byte position
  output logic                boeq0,
  output logic                boeq3
);

  fifo_pkg::byte_ptr_t bo_q;  // Byte pointer

  // Byte pointer
  always_ff @(posedge LLWS) begin
    if (reset || rst_fifo) begin
      bo_q <= fifo_pkg::BO_FIRST;
    end else if (acr_wr) begin
      bo_q <= mid25 ? fifo_pkg::BO_MID : fifo_pkg::BO_FIRST;
    end else if (lbyte) begin
      bo_q <= bo_q + 1'b1;  // Wraps 3 to 0
    end
  end

  // Request flag
  always_ff @(posedge LLWS) begin
    if (reset || rst_fifo) begin
      wr.req <= 1'b0;  // A flush drops a byte not yet stored
    end else if (lbyte) begin
      wr.req <= 1'b1;
    end else if (wr.gnt) begin
      wr.req <= 1'b0;
    end
  end

  // Payload for the single lane at the pointer
  always_ff @(posedge LLWS) begin
    if (lbyte) begin
      wr.data.bytes[bo_q] <= id[7:0];
      wr.lane_en          <= fifo_pkg::LANE_BYTE0 >> bo_q;
      wr.commit           <= (bo_q == fifo_pkg::BO_LAST);  // Fourth byte
    end
  end

  // Pointer status toward the DMA state machines
  assign bo    = bo_q;
  assign boeq0 = (bo_q == fifo_pkg::BO_FIRST);
  assign boeq3 = (bo_q == fifo_pkg::BO_LAST);

endmodule

// File: hdl/cpu_word_loader.sv
/* Host side loader, an entry is the high half on lhword then the low half on llword
   Strobes are single-cycle and must come at least 3 cycles apart */
`timescale 1ns/100ps

module cpu_word_loader (
  input  logic        LLWS,
  input  logic        reset,
  input  logic        lhword,  // Load upper half
  input  logic        llword,  // Load lower half, completes the entry
  input  logic [31:0] id,      // Host data
  fifo_wr_if.loader   wr
);

  logic strobe;  // Any half arrives

  assign strobe = lhword | llword;

  // Request flag
  always_ff @(posedge LLWS) begin
    if (reset) begin
      wr.req <= 1'b0;
    end else if (strobe) begin
      wr.req <= 1'b1;  // New half wins over a grant at the same edge
    end else if (wr.gnt) begin
      wr.req <= 1'b0;  // Transfer done
    end
  end

  // Request payload, held until granted
  always_ff @(posedge LLWS) begin
    if (strobe) begin
      wr.lane_en <= (lhword ? fifo_pkg::LANES_HIGH : 4'b0000)
                  | (llword ? fifo_pkg::LANES_LOW  : 4'b0000);
      wr.commit  <= llword;  // Low half ends the longword
    end
    if (lhword) wr.data.halves[0] <= id[31:16];
    if (llword) wr.data.halves[1] <= id[15:0];
  end

endmodule

// File: hdl/fifo_arbiter.sv
/* Fixed-priority arbiter for the buffer write port, the SCSI loader always wins
   Grants are combinational and a losing request simply waits for a later cycle */
`timescale 1ns/100ps

module fifo_arbiter (
  fifo_wr_if.arbiter cpu,      // Host word loader
  fifo_wr_if.arbiter scsi,     // SCSI byte loader
  fifo_wr_if.loader  buf_port  // Toward the buffer write port
);

  logic scsi_win;  // SCSI takes this cycle
  logic cpu_win;   // CPU takes this cycle

  // SCSI first, CPU only when SCSI is idle
  assign scsi_win = scsi.req & buf_port.gnt;
  assign cpu_win  = cpu.req & ~scsi.req & buf_port.gnt;

  assign scsi.gnt = scsi_win;
  assign cpu.gnt  = cpu_win;

  assign buf_port.req = scsi_win | cpu_win;  // Only a granted request goes through

  // Forward the fields of the winning side
  always_comb begin
    if (scsi.req) begin
      buf_port.lane_en = scsi.lane_en;
      buf_port.data    = scsi.data;
      buf_port.commit  = scsi.commit;
    end else begin
      buf_port.lane_en = cpu.lane_en;  // Also the idle default
      buf_port.data    = cpu.data;
      buf_port.commit  = cpu.commit;
    end
  end

endmodule

// File: fifo/fifo_buffer.sv
/* Longword FIFO storage with a single lane-enabled write port, always ready
   Any write while full is dropped, a pop while empty is ignored, od shows the head without delay */
`timescale 1ns/100ps

module fifo_buffer #(
  parameter int DEPTH = 8
) (
  input  logic                 LLWS,
  input  logic                 reset,
  input  logic                 rst_fifo,    // Flush back to empty
  input  logic                 pop,         // Head entry consumed
  fifo_wr_if.arbiter           wr,
  output fifo_pkg::fifo_word_t od,
  output logic                 fifo_full,
  output logic                 fifo_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fifo_pkg::fifo_word_t mem [DEPTH];  // Entry storage

  logic [PTR_W-1:0] wr_ptr;  // Next in
  logic [PTR_W-1:0] rd_ptr;  // Next out
  logic [CNT_W-1:0] count;   // Complete entries held

  logic write_ok;   // Lane write accepted
  logic do_commit;  // Entry completed
  logic do_pop;     // Head released

  assign wr.gnt = 1'b1;  // Storage never stalls

  assign fifo_full  = (count == CNT_W'(DEPTH));
  assign fifo_empty = (count == '0);

  assign write_ok  = wr.req & ~fifo_full;
  assign do_commit = write_ok & wr.commit;
  assign do_pop    = pop & ~fifo_empty;

  // Lane writes into the entry at the write pointer
  always_ff @(posedge LLWS) begin
    if (write_ok) begin
      for (int b = 0; b < 4; b++) begin
        if (wr.lane_en[3-b]) mem[wr_ptr].bytes[b] <= wr.data.bytes[b];
      end
    end
  end

  // Pointers and occupancy
  always_ff @(posedge LLWS) begin
    if (reset || rst_fifo) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_commit) begin
        // Wrap for any depth, not only powers of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_commit, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  assign od = mem[rd_ptr];  // Head entry, combinational read

endmodule

// File: common/fifo_wr_if.sv
/* One write request into the FIFO buffer
   Fields stay stable while req is high, and the transfer happens on the edge where gnt is high */
`timescale 1ns/100ps

interface fifo_wr_if;

  logic                req;      // Request pending
  logic                gnt;      // Transfer at this edge
  logic [3:0]          lane_en;  // Byte lanes to write, bit 3 is byte 0
  fifo_pkg::fifo_word_t data;    // Entry data, only enabled lanes count
  logic                commit;   // Last write of the entry, advances the write pointer

  // Request side
  modport loader (
    output req,
    output lane_en,
    output data,
    output commit,
    input  gnt
  );

  // Grant side
  modport arbiter (
    input  req,
    input  lane_en,
    input  data,
    input  commit,
    output gnt
  );

endinterface

// File: common/fifo_pkg.sv
/* Shared entry type and lane constants of the SCSI DMA data FIFO
   Byte 0 and half 0 are the most significant part of an entry, and lane bit 3 is byte 0 */
package fifo_pkg;

  // Byte position within an entry, 0 is the first byte on the SCSI bus
  typedef logic [1:0] byte_ptr_t;

  // One longword entry
  // The host side writes it by halves, the SCSI side by bytes
  typedef union packed {
    logic [0:3][7:0]  bytes;   // bytes[0] is bits 31:24
    logic [0:1][15:0] halves;  // halves[0] is bits 31:16
  } fifo_word_t;

  // Lane enables, bit 3 selects byte 0
  localparam logic [3:0] LANES_HIGH = 4'b1100;  // Bytes 0 and 1
  localparam logic [3:0] LANES_LOW  = 4'b0011;  // Bytes 2 and 3
  localparam logic [3:0] LANE_BYTE0 = 4'b1000;  // Shifted right by the byte pointer

  // Byte pointer positions
  localparam byte_ptr_t BO_FIRST = 2'd0;
  localparam byte_ptr_t BO_MID   = 2'd2;  // Start of a 16-bit aligned transfer
  localparam byte_ptr_t BO_LAST  = 2'd3;  // This byte completes the entry

endpackage
